//--- source/ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

////////////////////
// Datapath sizes
////////////////////

`define EX_XLEN        32  // Integer register and operand width
`define EX_RADDR_W     6   // Register file address incl. FP bank bit
`define EX_SHAMT_W     5   // Shift amount taken from operand_b

////////////////////
// Reset values
////////////////////

// Write address of the EX/WB register out of reset
`define EX_WB_RST_ADDR {`EX_RADDR_W{1'b0}}

`endif

//--- source/ex_op_pkg.sv
`include "ex_defs.svh"

package ex_op_pkg;

  // Integer ALU operations
  typedef enum logic [3:0] {
    ADD, SUB,                    // Arithmetic
    AND, OR, XOR,                // Bitwise logic
    SLL, SRL, SRA,               // Shifts
    SLT, SLTU,                   // Set-less-than, result is 0/1
    EQ, NE, LT, LTU, GE, GEU     // Branch compares
  } alu_opcode_e;

  // Integer multiply operations
  typedef enum logic [1:0] {
    MUL,     // Low half, single cycle
    MULH,    // High half, signed x signed
    MULHSU,  // High half, signed x unsigned
    MULHU    // High half, unsigned x unsigned
  } mul_opcode_e;

  // Multiplier FSM
  typedef enum logic {
    IDLE,    // Accept new op and latch product
    HIGH     // Present upper half
  } mult_state_e;

  // ALU request from ID
  typedef struct packed {
    logic                en;
    alu_opcode_e         operator;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
    logic [`EX_XLEN-1:0] operand_c;  // Jump target for branches
  } alu_req_t;

  // Multiplier request from ID
  typedef struct packed {
    logic                en;
    mul_opcode_e         operator;
    logic [`EX_XLEN-1:0] op_a;
    logic [`EX_XLEN-1:0] op_b;
  } mul_req_t;

endpackage

//--- source/ex_port_pkg.sv
`include "ex_defs.svh"

package ex_port_pkg;

  ////////////////////
  // Destination info
  ////////////////////

  // Handed from ID to EX with each instruction
  typedef struct packed {
    logic                   we;     // Instruction writes a register
    logic [`EX_RADDR_W-1:0] waddr;  // Target register
  } rf_dest_t;

  ////////////////////
  // Write ports
  ////////////////////

  // One register file write port, also used for forwarding to ID
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } wb_port_t;

endpackage

//--- source/ex_alu.sv
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_alu (
  input  ex_op_pkg::alu_req_t req_i,     // Operator and operands from ID
  output logic [`EX_XLEN-1:0] result_o,  // Written back on forwarding port
  output logic                cmp_o      // Branch decision / SLT bit
);

  logic [`EX_XLEN-1:0]    op_a;
  logic [`EX_XLEN-1:0]    op_b;
  logic                   sub_en;
  logic [`EX_XLEN:0]      adder_sum;    // Top bit is carry out
  logic                   lt_u;
  logic                   lt_s;
  logic                   eq;
  logic [`EX_SHAMT_W-1:0] shamt;
  logic                   shift_arith;
  logic [`EX_XLEN:0]      shift_ext;    // Extra bit carries sign for SRA
  logic [`EX_XLEN-1:0]    shift_left;
  logic [`EX_XLEN-1:0]    shift_right;

  assign op_a = req_i.operand_a;
  assign op_b = req_i.operand_b;

  ////////////////////
  // Adder
  ////////////////////

  // Everything except ADD subtracts, compares included
  assign sub_en    = (req_i.operator != ex_op_pkg::ADD);
  assign adder_sum = {1'b0, op_a} + {1'b0, sub_en ? ~op_b : op_b}
                   + {{`EX_XLEN{1'b0}}, sub_en};

  // No carry out of a - b means a < b unsigned
  assign lt_u = ~adder_sum[`EX_XLEN];
  // Sign of a decides when signs differ, else sign of difference
  assign lt_s = (op_a[`EX_XLEN-1] != op_b[`EX_XLEN-1]) ? op_a[`EX_XLEN-1]
                                                       : adder_sum[`EX_XLEN-1];
  assign eq   = (adder_sum[`EX_XLEN-1:0] == '0);  // Zero difference

  ////////////////////
  // Shifter
  ////////////////////

  assign shamt       = op_b[`EX_SHAMT_W-1:0];
  assign shift_arith = (req_i.operator == ex_op_pkg::SRA);
  assign shift_left  = op_a << shamt;
  assign shift_ext   = $unsigned($signed({shift_arith & op_a[`EX_XLEN-1], op_a}) >>> shamt);
  assign shift_right = shift_ext[`EX_XLEN-1:0];

  // Comparator
  always_comb begin
    cmp_o = 1'b0;  // Non-compare ops
    case (req_i.operator)
      ex_op_pkg::EQ:   cmp_o = eq;
      ex_op_pkg::NE:   cmp_o = ~eq;
      ex_op_pkg::SLT,
      ex_op_pkg::LT:   cmp_o = lt_s;
      ex_op_pkg::SLTU,
      ex_op_pkg::LTU:  cmp_o = lt_u;
      ex_op_pkg::GE:   cmp_o = ~lt_s;
      ex_op_pkg::GEU:  cmp_o = ~lt_u;
      default:         cmp_o = 1'b0;
    endcase
  end

  // Result mux
  always_comb begin
    case (req_i.operator)
      ex_op_pkg::ADD,
      ex_op_pkg::SUB:  result_o = adder_sum[`EX_XLEN-1:0];
      ex_op_pkg::AND:  result_o = op_a & op_b;
      ex_op_pkg::OR:   result_o = op_a | op_b;
      ex_op_pkg::XOR:  result_o = op_a ^ op_b;
      ex_op_pkg::SLL:  result_o = shift_left;
      ex_op_pkg::SRL,
      ex_op_pkg::SRA:  result_o = shift_right;
      default:         result_o = {{(`EX_XLEN-1){1'b0}}, cmp_o};  // Compares give 0/1
    endcase
  end

endmodule

//--- source/ex_mult.sv
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_op_pkg::mul_req_t req_i,         // Operator and operands from ID
  input  logic                ex_ready_i,    // Stage advances this cycle
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,       // Low while high half pending
  output logic                multicycle_o   // High half being presented
);

  ex_op_pkg::mult_state_e       state_q;
  ex_op_pkg::mult_state_e       state_d;
  logic                         sign_a;
  logic                         sign_b;
  logic signed [`EX_XLEN:0]     op_a_ext;      // One extra bit for unsigned forms
  logic signed [`EX_XLEN:0]     op_b_ext;
  logic signed [2*`EX_XLEN+1:0] product;
  logic [`EX_XLEN-1:0]          prod_hi_q;     // Upper half latched in IDLE
  logic                         high_req;

  ////////////////////
  // Datapath
  ////////////////////

  // Operand signedness per opcode, MUL low half is the same either way
  assign sign_a = (req_i.operator == ex_op_pkg::MULH) | (req_i.operator == ex_op_pkg::MULHSU);
  assign sign_b = (req_i.operator == ex_op_pkg::MULH);

  assign op_a_ext = $signed({sign_a & req_i.op_a[`EX_XLEN-1], req_i.op_a});
  assign op_b_ext = $signed({sign_b & req_i.op_b[`EX_XLEN-1], req_i.op_b});
  assign product  = op_a_ext * op_b_ext;  // Single signed 33x33 product

  assign high_req = req_i.en & (req_i.operator != ex_op_pkg::MUL);

  always_ff @(posedge clk) begin
    if (state_q == ex_op_pkg::IDLE) begin
      prod_hi_q <= product[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_op_pkg::IDLE: if (high_req)   state_d = ex_op_pkg::HIGH;  // Product captured now
      ex_op_pkg::HIGH: if (ex_ready_i) state_d = ex_op_pkg::IDLE;  // Result consumed
      default:                         state_d = ex_op_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_op_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs
  assign multicycle_o = (state_q == ex_op_pkg::HIGH);
  assign ready_o      = multicycle_o | ~high_req;  // MUL never stalls
  assign result_o     = multicycle_o ? prod_hi_q : product[`EX_XLEN-1:0];

endmodule

//--- source/ex_commit.sv
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_commit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  alu_en_i,
  input  logic [`EX_XLEN-1:0]   alu_result_i,
  input  logic                  mul_en_i,
  input  logic [`EX_XLEN-1:0]   mul_result_i,
  input  logic                  mul_ready_i,
  input  logic                  csr_access_i,
  input  logic [`EX_XLEN-1:0]   csr_rdata_i,
  input  ex_port_pkg::rf_dest_t alu_dest_i,      // Target of forwarding port
  input  ex_port_pkg::rf_dest_t lsu_dest_i,      // Target of load write
  input  logic                  lsu_en_i,
  input  logic [`EX_XLEN-1:0]   lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,  // EX part of LSU done
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  output ex_port_pkg::wb_port_t fwd_o,           // To RF and ID operand bypass
  output ex_port_pkg::wb_port_t wb_o,            // LSU write port
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic                   units_ready;
  logic                   we_lsu_q;
  logic [`EX_RADDR_W-1:0] waddr_lsu_q;

  ////////////////////
  // Forwarding port
  ////////////////////

  always_comb begin
    fwd_o.we    = alu_dest_i.we;
    fwd_o.waddr = alu_dest_i.waddr;
    if (csr_access_i) fwd_o.wdata = csr_rdata_i;   // CSR wins
    else if (mul_en_i) fwd_o.wdata = mul_result_i;
    else if (alu_en_i) fwd_o.wdata = alu_result_i;
    else               fwd_o.wdata = '0;
  end

  ////////////////////
  // Stall logic
  ////////////////////

  assign units_ready = mul_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve in EX and need no WB slot
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mul_en_i | csr_access_i | lsu_en_i) & units_ready;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q    <= 1'b0;
      waddr_lsu_q <= `EX_WB_RST_ADDR;
    end else if (ex_valid_o) begin
      we_lsu_q <= lsu_dest_i.we & ~lsu_err_i;  // Faulting load never writes
      if (lsu_dest_i.we & ~lsu_err_i) begin
        waddr_lsu_q <= lsu_dest_i.waddr;
      end
    end else if (wb_ready_i) begin
      we_lsu_q <= 1'b0;  // Bubble, flush pending write
    end
  end

  // Load data arrives straight from the LSU in the WB cycle
  assign wb_o = '{we: we_lsu_q, waddr: waddr_lsu_q, wdata: lsu_rdata_i};

endmodule

//--- source/ex_stage.sv
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_op_pkg::alu_req_t   alu_req_i,
  input  ex_op_pkg::mul_req_t   mul_req_i,
  input  logic                  csr_access_i,
  input  logic [`EX_XLEN-1:0]   csr_rdata_i,
  input  ex_port_pkg::rf_dest_t alu_dest_i,
  input  ex_port_pkg::rf_dest_t lsu_dest_i,
  input  logic                  lsu_en_i,
  input  logic [`EX_XLEN-1:0]   lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  output ex_port_pkg::wb_port_t fwd_o,
  output ex_port_pkg::wb_port_t wb_o,
  output logic [`EX_XLEN-1:0]   jump_target_o,      // To IF
  output logic                  branch_decision_o,  // To IF
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  // Branch outputs
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.operand_c;

  ////////////////////
  // Units
  ////////////////////

  ex_alu alu_i (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (mul_req_i),
    .ex_ready_i   (ex_ready_o),  // Releases HIGH state
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  // Write ports and stall control
  ex_commit commit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_en_i       (alu_req_i.en),
    .alu_result_i   (alu_result),
    .mul_en_i       (mul_req_i.en),
    .mul_result_i   (mult_result),
    .mul_ready_i    (mult_ready),
    .csr_access_i   (csr_access_i),
    .csr_rdata_i    (csr_rdata_i),
    .alu_dest_i     (alu_dest_i),
    .lsu_dest_i     (lsu_dest_i),
    .lsu_en_i       (lsu_en_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .lsu_err_i      (lsu_err_i),
    .branch_in_ex_i (branch_in_ex_i),
    .wb_ready_i     (wb_ready_i),
    .fwd_o          (fwd_o),
    .wb_o           (wb_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

//--- sim/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

`include "ex_defs.svh"

////////////////////
// ALU reference
////////////////////

// Compare bit, also the SLT/SLTU result
function automatic logic ref_cmp(input ex_op_pkg::alu_opcode_e op,
                                 input logic [`EX_XLEN-1:0] a,
                                 input logic [`EX_XLEN-1:0] b);
  case (op)
    ex_op_pkg::EQ:   return a == b;
    ex_op_pkg::NE:   return a != b;
    ex_op_pkg::SLT,
    ex_op_pkg::LT:   return $signed(a) < $signed(b);
    ex_op_pkg::SLTU,
    ex_op_pkg::LTU:  return a < b;
    ex_op_pkg::GE:   return $signed(a) >= $signed(b);
    ex_op_pkg::GEU:  return a >= b;
    default:         return 1'b0;  // Arithmetic and logic ops
  endcase
endfunction

function automatic logic [`EX_XLEN-1:0] ref_alu(input ex_op_pkg::alu_opcode_e op,
                                               input logic [`EX_XLEN-1:0] a,
                                               input logic [`EX_XLEN-1:0] b);
  logic [`EX_SHAMT_W-1:0] sh;
  sh = b[`EX_SHAMT_W-1:0];  // Only low bits shift
  case (op)
    ex_op_pkg::ADD:  return a + b;
    ex_op_pkg::SUB:  return a - b;
    ex_op_pkg::AND:  return a & b;
    ex_op_pkg::OR:   return a | b;
    ex_op_pkg::XOR:  return a ^ b;
    ex_op_pkg::SLL:  return a << sh;
    ex_op_pkg::SRL:  return a >> sh;
    ex_op_pkg::SRA:  return $signed(a) >>> sh;
    default:         return {{(`EX_XLEN-1){1'b0}}, ref_cmp(op, a, b)};
  endcase
endfunction

////////////////////
// Multiplier reference
////////////////////

// Full product in double width, wrap-around keeps it exact
function automatic logic [`EX_XLEN-1:0] ref_mult(input ex_op_pkg::mul_opcode_e op,
                                                input logic [`EX_XLEN-1:0] a,
                                                input logic [`EX_XLEN-1:0] b);
  logic [2*`EX_XLEN-1:0] a_w;
  logic [2*`EX_XLEN-1:0] b_w;
  logic [2*`EX_XLEN-1:0] p;
  a_w = {{`EX_XLEN{a[`EX_XLEN-1] & (op == ex_op_pkg::MULH || op == ex_op_pkg::MULHSU)}}, a};
  b_w = {{`EX_XLEN{b[`EX_XLEN-1] & (op == ex_op_pkg::MULH)}}, b};
  p   = a_w * b_w;
  return (op == ex_op_pkg::MUL) ? p[`EX_XLEN-1:0] : p[2*`EX_XLEN-1:`EX_XLEN];
endfunction

`endif

//--- sim/ex_stage_tb.sv
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_stage_tb;

  `include "ex_ref_model.svh"

  localparam int  N_ALU   = 200;
  localparam int  N_MUL   = 20;  // Per multiply form
  localparam int  N_PRIO  = 10;  // Per source combination
  localparam int  N_LSU   = 8;
  localparam int  N_VEC   = N_ALU + 4*N_MUL + 3*N_PRIO + N_LSU + 10;
  localparam time TIMEOUT = (N_VEC * 4 + 40) * 20;  // ns, 4 cycles per vector worst case

  logic                  clk;
  logic                  rst_n;
  ex_op_pkg::alu_req_t   alu_req;
  ex_op_pkg::mul_req_t   mul_req;
  logic                  csr_access;
  logic [`EX_XLEN-1:0]   csr_rdata;
  ex_port_pkg::rf_dest_t alu_dest;
  ex_port_pkg::rf_dest_t lsu_dest;
  logic                  lsu_en;
  logic [`EX_XLEN-1:0]   lsu_rdata;
  logic                  lsu_ready_ex;
  logic                  lsu_err;
  logic                  branch_in_ex;
  logic                  wb_ready;
  ex_port_pkg::wb_port_t fwd;
  ex_port_pkg::wb_port_t wb;
  logic [`EX_XLEN-1:0]   jump_target;
  logic                  branch_decision;
  logic                  mult_multicycle;
  logic                  ex_ready;
  logic                  ex_valid;

  string                  test_name;
  int                     errors;
  int                     checks;
  logic                   m_high;   // Expected multiplier in HIGH
  logic                   m_we;     // Expected EX/WB contents
  logic [`EX_RADDR_W-1:0] m_waddr;

  ex_stage dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .mul_req_i         (mul_req),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .alu_dest_i        (alu_dest),
    .lsu_dest_i        (lsu_dest),
    .lsu_en_i          (lsu_en),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_err_i         (lsu_err),
    .branch_in_ex_i    (branch_in_ex),
    .wb_ready_i        (wb_ready),
    .fwd_o             (fwd),
    .wb_o              (wb),
    .jump_target_o     (jump_target),
    .branch_decision_o (branch_decision),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  always #10 clk = ~clk;  // 20 ns period

  task automatic report_mismatch(input string what, input logic [`EX_XLEN-1:0] exp,
                                 input logic [`EX_XLEN-1:0] act);
    errors++;
    $display("Fail %s %s at %0t: expected %h, actual %h", test_name, what, $time, exp, act);
  endtask

  // Hold the current vector until EX accepts it, return on that edge
  task automatic wait_accept();
    @(negedge clk);
    while (!ex_ready) @(negedge clk);
    @(posedge clk);
  endtask

  function automatic ex_op_pkg::alu_req_t rand_alu();
    ex_op_pkg::alu_req_t req;
    req.en        = 1'b1;
    req.operator  = ex_op_pkg::alu_opcode_e'($urandom_range(15, 0));
    req.operand_a = $urandom;
    // Equal operands now and then so EQ and GE see both outcomes
    req.operand_b = ($urandom_range(3, 0) == 0) ? req.operand_a : $urandom;
    req.operand_c = $urandom;
    return req;
  endfunction

  ////////////////////
  // Compare process
  ////////////////////

  // Outputs are stable at the falling edge, model advances for the next rise
  always @(negedge clk) begin : compare
    logic                mul_high_op;
    logic                exp_mready;
    logic                exp_ready;
    logic                exp_valid;
    logic [`EX_XLEN-1:0] exp_data;
    if (!rst_n) begin
      m_high  = 1'b0;
      m_we    = 1'b0;
      m_waddr = `EX_WB_RST_ADDR;
    end else begin
      mul_high_op = mul_req.en & (mul_req.operator != ex_op_pkg::MUL);
      exp_mready  = m_high | ~mul_high_op;
      exp_ready   = (exp_mready & lsu_ready_ex & wb_ready) | branch_in_ex;
      exp_valid   = (alu_req.en | mul_req.en | csr_access | lsu_en)
                  & exp_mready & lsu_ready_ex & wb_ready;
      if (csr_access) exp_data = csr_rdata;  // Fixed source priority
      else if (mul_req.en) exp_data = ref_mult(mul_req.operator, mul_req.op_a, mul_req.op_b);
      else if (alu_req.en) exp_data = ref_alu(alu_req.operator, alu_req.operand_a,
                                              alu_req.operand_b);
      else exp_data = '0;
      checks++;
      if (ex_ready !== exp_ready) report_mismatch("ex_ready_o", exp_ready, ex_ready);
      if (ex_valid !== exp_valid) report_mismatch("ex_valid_o", exp_valid, ex_valid);
      if (mult_multicycle !== m_high) report_mismatch("mult_multicycle_o", m_high, mult_multicycle);
      if (wb.we !== m_we) report_mismatch("wb_o.we", m_we, wb.we);
      if (wb.waddr !== m_waddr) report_mismatch("wb_o.waddr", m_waddr, wb.waddr);
      if (wb.wdata !== lsu_rdata) report_mismatch("wb_o.wdata", lsu_rdata, wb.wdata);
      if (fwd.we !== alu_dest.we) report_mismatch("fwd_o.we", alu_dest.we, fwd.we);
      if (fwd.waddr !== alu_dest.waddr) report_mismatch("fwd_o.waddr", alu_dest.waddr, fwd.waddr);
      // First cycle of a high form carries no valid data
      if ((csr_access | ~mul_high_op | m_high) && fwd.wdata !== exp_data)
        report_mismatch("fwd_o.wdata", exp_data, fwd.wdata);
      if (branch_decision !== ref_cmp(alu_req.operator, alu_req.operand_a, alu_req.operand_b))
        report_mismatch("branch_decision_o",
                        ref_cmp(alu_req.operator, alu_req.operand_a, alu_req.operand_b),
                        branch_decision);
      if (jump_target !== alu_req.operand_c)
        report_mismatch("jump_target_o", alu_req.operand_c, jump_target);
      // Next state
      m_high = m_high ? ~exp_ready : mul_high_op;
      if (exp_valid) begin
        m_we = lsu_dest.we & ~lsu_err;
        if (m_we) m_waddr = lsu_dest.waddr;
      end else if (wb_ready) begin
        m_we = 1'b0;  // Bubble flush
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    void'($urandom(25));
    errors       = 0;
    checks       = 0;
    test_name    = "reset";
    clk          = 1'b0;
    rst_n        = 1'b0;
    alu_req      = '0;
    mul_req      = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    alu_dest     = '0;
    lsu_dest     = '0;
    lsu_en       = 1'b0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);  // Reset values checked on the falling edge before this

    test_name = "alu";
    for (int i = 0; i < N_ALU; i++) begin
      alu_req  <= rand_alu();
      alu_dest <= '{we: 1'($urandom), waddr: `EX_RADDR_W'($urandom)};
      wait_accept();
    end
    alu_req <= '0;

    test_name = "mult";  // MUL, then MULH, MULHSU, MULHU
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < N_MUL; i++) begin
        mul_req <= '{en: 1'b1, operator: ex_op_pkg::mul_opcode_e'(op),
                     op_a: $urandom, op_b: $urandom};
        wait_accept();
      end
    end

    test_name = "priority";  // All on, then CSR off, then only ALU
    for (int i = 0; i < 3*N_PRIO; i++) begin
      alu_req    <= rand_alu();
      mul_req    <= '{en: (i < 2*N_PRIO), operator: ex_op_pkg::MUL,
                      op_a: $urandom, op_b: $urandom};
      csr_access <= (i < N_PRIO);
      csr_rdata  <= $urandom;
      wait_accept();
    end
    alu_req    <= '0;
    mul_req    <= '0;
    csr_access <= 1'b0;

    test_name = "lsu";  // Load, faulting load, load, idle flush
    for (int i = 0; i < N_LSU; i++) begin
      lsu_en    <= (i % 4 != 3);
      lsu_err   <= (i % 4 == 1);
      lsu_dest  <= '{we: 1'b1, waddr: `EX_RADDR_W'($urandom)};
      lsu_rdata <= $urandom;
      wait_accept();
    end

    test_name = "backpressure";
    lsu_en   <= 1'b1;
    lsu_err  <= 1'b0;
    lsu_dest <= '{we: 1'b1, waddr: `EX_RADDR_W'($urandom)};
    wait_accept();  // Leaves a pending load write
    wb_ready <= 1'b0;
    lsu_dest <= '{we: 1'b1, waddr: `EX_RADDR_W'($urandom)};
    repeat (3) @(posedge clk);
    branch_in_ex <= 1'b1;
    repeat (2) @(posedge clk);
    branch_in_ex <= 1'b0;
    wb_ready     <= 1'b1;
    lsu_ready_ex <= 1'b0;  // LSU stall alone holds EX
    repeat (2) @(posedge clk);
    lsu_ready_ex <= 1'b1;
    lsu_en       <= 1'b0;
    lsu_dest     <= '0;
    wait_accept();
    repeat (2) @(posedge clk);

    $display("Summary: %0d errors in %0d checked cycles", errors, checks);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout: EX stage test did not finish within %0t", TIMEOUT);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+source
+incdir+sim
source/ex_op_pkg.sv
source/ex_port_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_commit.sv
source/ex_stage.sv
sim/ex_stage_tb.sv
